/* dv/tb_glb.sv */
// Random fill and stream traffic over two layer configurations
// Weight ready is held high, activation ready is random; each stream replays 1 or 2 times
`default_nettype none

module tb_glb;

    localparam int NUM_BANKS   = 8;
    localparam int BANK_ADDR_W = 5;
    localparam int DATA_W      = 128;
    localparam int DEPTH       = 2 ** BANK_ADDR_W;
    localparam int WAIT_LIMIT  = 20000;

    logic                clk;
    logic                rst_n;
    logic                cfg_val_i;
    logic                cfg_rdy_o;
    glb_pkg::glb_cfg_t   cfg_i;
    logic                req_val_o;
    logic                req_rdy_i;
    glb_pkg::data_kind_e req_kind_o;
    logic                in_val_i;
    logic                in_rdy_o;
    logic [DATA_W-1:0]   in_data_i;
    logic                wei_val_o;
    logic                wei_rdy_i;
    logic [DATA_W-1:0]   wei_data_o;
    logic                pullback_wei_i;
    logic                act_val_o;
    logic                act_rdy_i;
    logic [DATA_W-1:0]   act_data_o;
    logic                pullback_act_i;

    integer seed;
    int     checks;
    int     val_errs;
    int     other_errs;

    // ----------------------------------------
    // Model of the current layer
    glb_pkg::glb_cfg_t cur_cfg;
    logic [DATA_W-1:0] wei_q[$];
    logic [DATA_W-1:0] act_q[$];
    logic [DATA_W-1:0] act_held;
    int   req_cnt;
    int   wei_idx;
    int   act_idx;
    int   wei_replays;
    int   act_replays;
    int   wei_target;   // Pullbacks asked for in this layer
    int   act_target;
    logic busy;
    logic wei_fin;
    logic act_fin;
    logic wei_started;
    logic act_stalled;
    logic layer_idle;

    glb_top #(
        .NUM_BANKS   (NUM_BANKS),
        .BANK_ADDR_W (BANK_ADDR_W),
        .DATA_W      (DATA_W)
    ) glb_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            val_errs++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_fail(input string msg);
        other_errs++;
        $display("%s at %0t", msg, $time);
    endtask

    task automatic end_run();
        $display("checks %0d, value errors %0d, other errors %0d", checks, val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // Regions fit the banks; every field differs from the previous layer
    task automatic make_cfg(input glb_pkg::glb_cfg_t prev, output glb_pkg::glb_cfg_t c);
        int banks;
        int n_wei;
        int n_act;
        do begin
            banks = 1 + int'($unsigned($random(seed)) % (NUM_BANKS - 1));
            n_wei = 1 + int'($unsigned($random(seed)) % (banks * DEPTH));
            n_act = 1 + int'($unsigned($random(seed)) % ((NUM_BANKS - banks) * DEPTH));
        end while (banks == int'(prev.banks_wei) || n_wei == int'(prev.words_wei)
                   || n_act == int'(prev.words_act));
        c.banks_wei = banks[glb_pkg::BANK_CNT_W-1:0];
        c.words_wei = n_wei[glb_pkg::WORD_CNT_W-1:0];
        c.words_act = n_act[glb_pkg::WORD_CNT_W-1:0];
        wei_target  = 1 + int'($unsigned($random(seed)) % 2);
        act_target  = 1 + int'($unsigned($random(seed)) % 2);
    endtask

    task automatic send_cfg(input glb_pkg::glb_cfg_t c, output bit ok);
        int cycles;
        cycles = 0;
        @(posedge clk);
        cfg_i     <= c;
        cfg_val_i <= 1'b1;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cfg_rdy_o && cycles < WAIT_LIMIT);
        ok = cfg_rdy_o;
        if (!ok) begin
            report_fail("timeout waiting for cfg_rdy_o to accept a configuration");
        end else begin
            @(posedge clk);
            cfg_val_i <= 1'b0;
        end
    endtask

    task automatic wait_layer_end(output bit ok);
        int cycles;
        cycles = 0;
        while (!layer_idle && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        ok = layer_idle;
        if (!ok) begin
            report_fail("timeout waiting for both streams to finish and cfg_rdy_o to return");
        end
    endtask

    task automatic check_layer();
        check_val("wei region words", DATA_W'(wei_q.size()), DATA_W'(cur_cfg.words_wei));
        check_val("act region words", DATA_W'(act_q.size()), DATA_W'(cur_cfg.words_act));
        check_val("fill requests", DATA_W'(req_cnt), DATA_W'(2));
    endtask

    // ----------------------------------------
    // Random upstream and consumer behavior
    always @(posedge clk) begin : drive_inputs
        int r;
        if (rst_n) begin
            r = $random(seed);
            req_rdy_i      <= r[0];
            in_val_i       <= r[1];
            act_rdy_i      <= (r[3:2] != 2'b00);
            wei_rdy_i      <= 1'b1;
            pullback_wei_i <= (wei_replays < wei_target);
            pullback_act_i <= (act_replays < act_target);
            in_data_i      <= {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
    end

    // Sampled mid cycle, ahead of the edge that makes the transfer
    always @(negedge clk) begin : monitor
        if (rst_n) begin
            if (busy && !(wei_fin && act_fin)) begin
                check_val("cfg_rdy_o", DATA_W'(cfg_rdy_o), '0);
            end
            if (cfg_val_i && cfg_rdy_o) begin
                cur_cfg = cfg_i;
                wei_q.delete();
                act_q.delete();
                req_cnt     = 0;
                wei_idx     = 0;
                act_idx     = 0;
                wei_replays = 0;
                act_replays = 0;
                busy        = 1'b1;
                wei_fin     = 1'b0;
                act_fin     = 1'b0;
                wei_started = 1'b0;
            end
            // Fill side
            if (req_cnt == 0 || (req_cnt == 1 && wei_q.size() == int'(cur_cfg.words_wei))
                || (req_cnt >= 2 && act_q.size() == int'(cur_cfg.words_act))) begin
                check_val("in_rdy_o", DATA_W'(in_rdy_o), '0);
            end
            if (req_val_o && req_rdy_i) begin
                if (req_cnt >= 2) begin
                    report_fail("fill request after both regions were requested");
                end else begin
                    check_val("req_kind_o", DATA_W'(req_kind_o),
                              DATA_W'(req_cnt == 0 ? glb_pkg::KIND_WEI : glb_pkg::KIND_ACT));
                end
                req_cnt++;
            end
            if (in_val_i && in_rdy_o) begin
                if (req_cnt == 1 && wei_q.size() < int'(cur_cfg.words_wei)) begin
                    wei_q.push_back(in_data_i);
                end else if (req_cnt == 2 && act_q.size() < int'(cur_cfg.words_act)) begin
                    act_q.push_back(in_data_i);
                end else begin
                    report_fail("data word accepted outside a fill phase");
                end
            end
            // Weight stream, one word per cycle once started
            if (wei_started) begin
                check_val("wei_val_o", DATA_W'(wei_val_o), DATA_W'(!wei_fin));
            end
            if (wei_val_o && wei_rdy_i) begin
                wei_started = 1'b1;
                if (wei_idx < wei_q.size()) begin
                    check_val("wei_data_o", wei_data_o, wei_q[wei_idx]);
                end else begin
                    report_fail("weight word streamed beyond the filled words");
                end
                wei_idx++;
                if (wei_idx == int'(cur_cfg.words_wei)) begin
                    wei_idx = 0;
                    if (pullback_wei_i) wei_replays++;
                    else wei_fin = 1'b1;
                end
            end
            // Activation stream, data held while stalled
            if (act_stalled) begin
                check_val("act_val_o", DATA_W'(act_val_o), DATA_W'(1'b1));
                check_val("act_data_o", act_data_o, act_held);
            end
            if (act_fin) begin
                check_val("act_val_o", DATA_W'(act_val_o), '0);
            end
            act_stalled = act_val_o && !act_rdy_i;
            act_held    = act_data_o;
            if (act_val_o && act_rdy_i) begin
                if (act_idx < act_q.size()) begin
                    check_val("act_data_o", act_data_o, act_q[act_idx]);
                end else begin
                    report_fail("activation word streamed beyond the filled words");
                end
                act_idx++;
                if (act_idx == int'(cur_cfg.words_act)) begin
                    act_idx = 0;
                    if (pullback_act_i) act_replays++;
                    else act_fin = 1'b1;
                end
            end
            layer_idle = wei_fin && act_fin && cfg_rdy_o;
        end
    end

    // ----------------------------------------
    // Two layers with different region splits
    initial begin
        glb_pkg::glb_cfg_t cfg_a;
        glb_pkg::glb_cfg_t cfg_b;
        bit                ok;
        seed           = 32'h1a1;
        checks         = 0;
        val_errs       = 0;
        other_errs     = 0;
        req_cnt        = 0;
        wei_replays    = 0;
        act_replays    = 0;
        wei_target     = 0;
        act_target     = 0;
        busy           = 1'b0;
        wei_fin        = 1'b0;
        act_fin        = 1'b0;
        wei_started    = 1'b0;
        act_stalled    = 1'b0;
        layer_idle     = 1'b0;
        rst_n          = 1'b0;
        cfg_val_i      = 1'b0;
        cfg_i          = '0;
        req_rdy_i      = 1'b0;
        in_val_i       = 1'b0;
        in_data_i      = '0;
        wei_rdy_i      = 1'b0;
        act_rdy_i      = 1'b0;
        pullback_wei_i = 1'b0;
        pullback_act_i = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("cfg_rdy_o", DATA_W'(cfg_rdy_o), DATA_W'(1'b1));
        check_val("req_val_o", DATA_W'(req_val_o), '0);
        check_val("in_rdy_o", DATA_W'(in_rdy_o), '0);
        check_val("wei_val_o", DATA_W'(wei_val_o), '0);
        check_val("act_val_o", DATA_W'(act_val_o), '0);
        make_cfg('0, cfg_a);
        send_cfg(cfg_a, ok);
        if (ok) begin
            wait_layer_end(ok);
        end
        if (ok) begin
            check_layer();
            @(negedge clk);
            make_cfg(cfg_a, cfg_b);   // New bank split remaps the activation region
            send_cfg(cfg_b, ok);
        end
        if (ok) begin
            wait_layer_end(ok);
        end
        if (ok) begin
            check_layer();
        end
        end_run();
    end

endmodule

`default_nettype wire

/* logic/glb_bank_array.sv */
// Banks with one write port and two asynchronous read ports
// Regions must fit inside NUM_BANKS banks
`default_nettype none

module glb_bank_array #(
    parameter int NUM_BANKS   = 8,
    parameter int BANK_ADDR_W = 5,
    parameter int DATA_W      = 128
) (
    input  wire                              clk,
    input  wire glb_pkg::glb_cfg_t           cfg_i,
    input  wire glb_pkg::glb_wr_t            wr_i,
    input  wire [DATA_W-1:0]                 wr_data_i,
    input  wire [glb_pkg::WORD_CNT_W-1:0]    wei_rd_off_i,
    input  wire [glb_pkg::WORD_CNT_W-1:0]    act_rd_off_i,
    output logic [DATA_W-1:0]                wei_rd_data_o,
    output logic [DATA_W-1:0]                act_rd_data_o
);

    localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
    localparam int BASE_W = glb_pkg::BANK_CNT_W + BANK_ADDR_W;
    localparam int GLB_W  = ((BASE_W > glb_pkg::WORD_CNT_W) ? BASE_W
                                                            : glb_pkg::WORD_CNT_W) + 1;
    localparam int DEPTH  = 2 ** BANK_ADDR_W;

    logic [DATA_W-1:0] mem [NUM_BANKS][DEPTH];
    logic [GLB_W-1:0]  wr_glb;
    logic [GLB_W-1:0]  wei_glb;
    logic [GLB_W-1:0]  act_glb;

    // Region offset to flat word index; upper bits select the bank
    function automatic logic [GLB_W-1:0] region_map(
        input glb_pkg::data_kind_e                 kind,
        input logic [glb_pkg::BANK_CNT_W-1:0]      banks_wei,
        input logic [glb_pkg::WORD_CNT_W-1:0]      off
    );
        logic [GLB_W-1:0] base;
        base = '0;
        if (kind == glb_pkg::KIND_ACT) begin
            base = GLB_W'(banks_wei) << BANK_ADDR_W;
        end
        return base + GLB_W'(off);
    endfunction

    assign wr_glb  = region_map(wr_i.kind, cfg_i.banks_wei, wr_i.offset);
    assign wei_glb = region_map(glb_pkg::KIND_WEI, cfg_i.banks_wei, wei_rd_off_i);
    assign act_glb = region_map(glb_pkg::KIND_ACT, cfg_i.banks_wei, act_rd_off_i);

    // ----------------------------------------
    // Write port
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            mem[wr_glb[BANK_ADDR_W +: BANK_W]][wr_glb[BANK_ADDR_W-1:0]] <= wr_data_i;
        end
    end

    // Read ports
    assign wei_rd_data_o = mem[wei_glb[BANK_ADDR_W +: BANK_W]][wei_glb[BANK_ADDR_W-1:0]];
    assign act_rd_data_o = mem[act_glb[BANK_ADDR_W +: BANK_W]][act_glb[BANK_ADDR_W-1:0]];

endmodule

`default_nettype wire

/* logic/glb_cfg_ctrl.sv */
// Holds one layer configuration. The register is stable while the layer is busy
`default_nettype none

module glb_cfg_ctrl (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    cfg_val_i,
    output logic                   cfg_rdy_o,
    input  wire glb_pkg::glb_cfg_t cfg_i,
    output glb_pkg::glb_cfg_t      cfg_o,
    output logic                   load_start_o,
    input  wire                    wei_done_i,
    input  wire                    act_done_i
);

    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   cfg_xfer;
    logic   layer_end;

    assign cfg_xfer  = cfg_val_i && cfg_rdy_o;
    assign cfg_rdy_o = (state_q == IDLE);

    // Done flags of the last layer are still up during load_start
    assign layer_end = wei_done_i && act_done_i && !load_start_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cfg_xfer) begin
                    state_d = BUSY;
                end
            end
            BUSY: begin
                if (layer_end) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            load_start_o <= 1'b0;
        end else begin
            state_q      <= state_d;
            load_start_o <= cfg_xfer;   // Same cycle as cfg_rdy_o falls
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_xfer) begin
            cfg_o <= cfg_i;
        end
    end

endmodule

`default_nettype wire

/* logic/glb_drain_ctrl.sv */
// Streams one region from offset 0 under valid/ready
// Pullback is sampled only on the last transfer of a pass
`default_nettype none

module glb_drain_ctrl #(
    parameter int DATA_W = 128
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 load_start_i,
    input  wire                                 filled_i,
    input  wire [glb_pkg::WORD_CNT_W-1:0]       words_i,
    output logic [glb_pkg::WORD_CNT_W-1:0]      rd_off_o,
    input  wire [DATA_W-1:0]                    rd_data_i,
    output logic                                val_o,
    input  wire                                 rdy_i,
    output logic [DATA_W-1:0]                   data_o,
    input  wire                                 pullback_i,
    output logic                                done_o
);

    localparam logic [glb_pkg::WORD_CNT_W-1:0] WORD_ONE =
        {{(glb_pkg::WORD_CNT_W-1){1'b0}}, 1'b1};

    logic fetch_en;   // More words of this pass to load
    logic out_last;   // Output register holds the last word of a pass
    logic advance;
    logic xfer;
    logic pass_end;
    logic replay;
    logic load;
    logic at_last;

    assign advance  = !val_o || rdy_i;
    assign xfer     = val_o && rdy_i;
    assign pass_end = xfer && out_last;
    assign replay   = pass_end && pullback_i;
    assign at_last  = (rd_off_o == words_i - WORD_ONE);

    // First pass starts on filled, replays start on pass end
    assign load = advance && (filled_i || replay || fetch_en);

    // ----------------------------------------
    // Read offset and output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_off_o <= '0;
            fetch_en <= 1'b0;
            out_last <= 1'b0;
            val_o    <= 1'b0;
        end else if (load) begin
            val_o    <= 1'b1;
            out_last <= at_last;
            fetch_en <= !at_last;
            rd_off_o <= at_last ? '0 : rd_off_o + WORD_ONE;   // Wraps for replay
        end else if (xfer) begin
            val_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_o <= rd_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_o <= 1'b0;
        end else if (load_start_i) begin
            done_o <= 1'b0;
        end else if (pass_end && !pullback_i) begin
            done_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/glb_fill_ctrl.sv */
// Fills the weight region, then the activation region, one request each
// Word counts must be at least 1
`default_nettype none

module glb_fill_ctrl #(
    parameter int DATA_W = 128
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    load_start_i,
    input  wire glb_pkg::glb_cfg_t cfg_i,
    output logic                   req_val_o,
    input  wire                    req_rdy_i,
    output glb_pkg::data_kind_e    req_kind_o,
    input  wire                    in_val_i,
    output logic                   in_rdy_o,
    input  wire [DATA_W-1:0]       in_data_i,
    output glb_pkg::glb_wr_t       wr_o,
    output logic [DATA_W-1:0]      wr_data_o,
    output logic                   wei_filled_o,
    output logic                   act_filled_o
);

    localparam logic [glb_pkg::WORD_CNT_W-1:0] WORD_ONE =
        {{(glb_pkg::WORD_CNT_W-1){1'b0}}, 1'b1};

    typedef enum logic [2:0] {
        IDLE,
        REQ_WEI,
        LOAD_WEI,
        REQ_ACT,
        LOAD_ACT
    } state_e;

    state_e                         state_q;
    state_e                         state_d;
    glb_pkg::data_kind_e            kind;
    logic [glb_pkg::WORD_CNT_W-1:0] word_cnt;
    logic [glb_pkg::WORD_CNT_W-1:0] last_off;
    logic                           in_xfer;
    logic                           last_word;

    assign kind = (state_q == REQ_WEI || state_q == LOAD_WEI) ? glb_pkg::KIND_WEI
                                                              : glb_pkg::KIND_ACT;
    assign last_off = ((kind == glb_pkg::KIND_WEI) ? cfg_i.words_wei : cfg_i.words_act)
                      - WORD_ONE;

    assign req_val_o  = (state_q == REQ_WEI) || (state_q == REQ_ACT);
    assign req_kind_o = kind;   // Follows the state, so stable under valid
    assign in_rdy_o   = (state_q == LOAD_WEI) || (state_q == LOAD_ACT);
    assign in_xfer    = in_val_i && in_rdy_o;
    assign last_word  = in_xfer && (word_cnt == last_off);

    // ----------------------------------------
    // Phase sequence
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:     if (load_start_i) state_d = REQ_WEI;
            REQ_WEI:  if (req_rdy_i)    state_d = LOAD_WEI;
            LOAD_WEI: if (last_word)    state_d = REQ_ACT;
            REQ_ACT:  if (req_rdy_i)    state_d = LOAD_ACT;
            LOAD_ACT: if (last_word)    state_d = IDLE;
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            word_cnt     <= '0;
            wei_filled_o <= 1'b0;
            act_filled_o <= 1'b0;
        end else begin
            state_q      <= state_d;
            wei_filled_o <= last_word && (state_q == LOAD_WEI);
            act_filled_o <= last_word && (state_q == LOAD_ACT);
            if (load_start_i || last_word) begin
                word_cnt <= '0;
            end else if (in_xfer) begin
                word_cnt <= word_cnt + WORD_ONE;
            end
        end
    end

    // Write lands on the transfer edge
    always_comb begin
        wr_o.kind   = kind;
        wr_o.offset = word_cnt;
        wr_o.en     = in_xfer;
    end

    assign wr_data_o = in_data_i;

endmodule

`default_nettype wire

/* logic/glb_pkg.sv */
// Shared types of the global buffer. Word counts and offsets count bank words
// Region sizes are not range checked in hardware
`default_nettype none

package glb_pkg;

    // ----------------------------------------
    // Counter widths
    localparam int BANK_CNT_W = 4;   // Bank count
    localparam int WORD_CNT_W = 12;  // Words in one region

    // Data kind of a fill request or a bank write
    typedef enum logic {
        KIND_WEI = 1'b0,
        KIND_ACT = 1'b1
    } data_kind_e;

    // ----------------------------------------
    // Layer configuration
    // Activation region begins at bank banks_wei
    typedef struct packed {
        logic [BANK_CNT_W-1:0] banks_wei;
        logic [WORD_CNT_W-1:0] words_wei;
        logic [WORD_CNT_W-1:0] words_act;
    } glb_cfg_t;

    // Fill to bank array write command
    typedef struct packed {
        data_kind_e            kind;
        logic [WORD_CNT_W-1:0] offset;   // Word offset inside the region
        logic                  en;
    } glb_wr_t;

endpackage

`default_nettype wire

/* logic/glb_top.sv */
// Global buffer for one layer. Weights fill the low banks, activations follow
// A new configuration is taken only after both streams have finished
`default_nettype none

module glb_top #(
    parameter int NUM_BANKS   = 8,
    parameter int BANK_ADDR_W = 5,
    parameter int DATA_W      = 128
) (
    input  wire                       clk,
    input  wire                       rst_n,
    // Configuration
    input  wire                       cfg_val_i,
    output logic                      cfg_rdy_o,
    input  wire glb_pkg::glb_cfg_t    cfg_i,
    // Fill request
    output logic                      req_val_o,
    input  wire                       req_rdy_i,
    output glb_pkg::data_kind_e       req_kind_o,
    // Fill data
    input  wire                       in_val_i,
    output logic                      in_rdy_o,
    input  wire [DATA_W-1:0]          in_data_i,
    // Weight stream
    output logic                      wei_val_o,
    input  wire                       wei_rdy_i,
    output logic [DATA_W-1:0]         wei_data_o,
    input  wire                       pullback_wei_i,
    // Activation stream
    output logic                      act_val_o,
    input  wire                       act_rdy_i,
    output logic [DATA_W-1:0]         act_data_o,
    input  wire                       pullback_act_i
);

    glb_pkg::glb_cfg_t              cfg;
    logic                           load_start;
    glb_pkg::glb_wr_t               wr;
    logic [DATA_W-1:0]              wr_data;
    logic                           wei_filled;
    logic                           act_filled;
    logic                           wei_done;
    logic                           act_done;
    logic [glb_pkg::WORD_CNT_W-1:0] wei_rd_off;
    logic [glb_pkg::WORD_CNT_W-1:0] act_rd_off;
    logic [DATA_W-1:0]              wei_rd_data;
    logic [DATA_W-1:0]              act_rd_data;

    glb_cfg_ctrl u_cfg_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_val_i    (cfg_val_i),
        .cfg_rdy_o    (cfg_rdy_o),
        .cfg_i        (cfg_i),
        .cfg_o        (cfg),
        .load_start_o (load_start),
        .wei_done_i   (wei_done),
        .act_done_i   (act_done)
    );

    glb_fill_ctrl #(
        .DATA_W (DATA_W)
    ) u_fill_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_start_i (load_start),
        .cfg_i        (cfg),
        .req_val_o    (req_val_o),
        .req_rdy_i    (req_rdy_i),
        .req_kind_o   (req_kind_o),
        .in_val_i     (in_val_i),
        .in_rdy_o     (in_rdy_o),
        .in_data_i    (in_data_i),
        .wr_o         (wr),
        .wr_data_o    (wr_data),
        .wei_filled_o (wei_filled),
        .act_filled_o (act_filled)
    );

    glb_bank_array #(
        .NUM_BANKS   (NUM_BANKS),
        .BANK_ADDR_W (BANK_ADDR_W),
        .DATA_W      (DATA_W)
    ) u_bank_array (
        .clk           (clk),
        .cfg_i         (cfg),
        .wr_i          (wr),
        .wr_data_i     (wr_data),
        .wei_rd_off_i  (wei_rd_off),
        .act_rd_off_i  (act_rd_off),
        .wei_rd_data_o (wei_rd_data),
        .act_rd_data_o (act_rd_data)
    );

    // ----------------------------------------
    // One drain per region
    glb_drain_ctrl #(
        .DATA_W (DATA_W)
    ) u_drain_wei (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_start_i (load_start),
        .filled_i     (wei_filled),
        .words_i      (cfg.words_wei),
        .rd_off_o     (wei_rd_off),
        .rd_data_i    (wei_rd_data),
        .val_o        (wei_val_o),
        .rdy_i        (wei_rdy_i),
        .data_o       (wei_data_o),
        .pullback_i   (pullback_wei_i),
        .done_o       (wei_done)
    );

    glb_drain_ctrl #(
        .DATA_W (DATA_W)
    ) u_drain_act (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_start_i (load_start),
        .filled_i     (act_filled),
        .words_i      (cfg.words_act),
        .rd_off_o     (act_rd_off),
        .rd_data_i    (act_rd_data),
        .val_o        (act_val_o),
        .rdy_i        (act_rdy_i),
        .data_o       (act_data_o),
        .pullback_i   (pullback_act_i),
        .done_o       (act_done)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build with Verilator, run the testbench, then look for the pass line in sim.log
rm -f sim.log && \
verilator --binary --timing -f src.f --top-module tb_glb -Mdir obj_dir -o tb_glb \
    > build.log 2>&1 && \
./obj_dir/tb_glb > sim.log 2>&1
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL, see build.log and sim.log"; exit 1; }

/* src.f */
logic/glb_pkg.sv
logic/glb_cfg_ctrl.sv
logic/glb_fill_ctrl.sv
logic/glb_bank_array.sv
logic/glb_drain_ctrl.sv
logic/glb_top.sv
dv/tb_glb.sv
